//--- sources.f
cpu_pkg.sv
cpu_intf.sv
register_file.sv
fetch_decode.sv
stage_reg.sv
execute_unit.sv
cpu_top.sv
cpu_properties.sv
tb_cpu.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_cpu
FILELIST = sources.f
OBJ_DIR = obj_dir
SIM_BIN = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
RUN_FLAGS = +verilator+error+limit+1000
PASS_TEXT = Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
	import cpu_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 5;
	localparam int RESET_CYCLES = 5;
	localparam int IMEM_DEPTH = 64;
	localparam int PROG_LEN = 40;
	localparam int NUM_RUNS = 3;
	localparam int LOAD_CYCLES = 4 * PROG_LEN; // write and read back at two cycles per word
	localparam int WATCHDOG_CYCLES = NUM_RUNS * (LOAD_CYCLES + 2 * IMEM_DEPTH + 50);

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic psel = 1'b0;
	logic penable = 1'b0;
	logic pwrite = 1'b0;
	logic [APB_ADDR_W-1:0] paddr = '0;
	word_t pwdata = '0;
	word_t prdata;
	logic pready;
	logic pslverr;
	word_t in_value = '0;
	word_t out_value;
	logic out_valid;
	flags_t flags;

	integer seed = 39;
	int checks = 0;
	int value_errors = 0;
	int other_errors = 0;
	int run_outs = 0;

	word_t prog [PROG_LEN];
	word_t model_regs [NUM_REGS]; // ISA model state kept across runs
	flags_t model_flags;
	word_t exp_out [$];

	cpu_top #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.in_value(in_value),
		.out_value(out_value),
		.out_valid(out_valid),
		.flags(flags)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("ERROR: watchdog timeout, run not done after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		checks++;
		assert (actual === expected) else begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	// setup then access cycle starting and ending just after a rising edge
	task automatic apb_transfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
			input word_t wdata, output word_t rdata, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#DRIVE_DELAY;
		penable = 1'b1;
		@(negedge clk);
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#DRIVE_DELAY;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input word_t data,
			output logic err);
		word_t unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output word_t data,
			output logic err);
		apb_transfer(1'b0, addr, '0, data, err);
	endtask

	task automatic build_program();
		int pos;
		int pick;
		opcode_e op;
		reg_addr_t prev_rd;
		word_t w;
		pos = 0;
		prev_rd = '0;
		while (pos < PROG_LEN - 1) begin
			pick = int'({$random(seed)} % 16);
			op = (pick > int'(OUT)) ? OUT : opcode_e'(pick[OPC_W-1:0]); // OUT weighted up
			if (op == LDM && pos == PROG_LEN - 2) op = MOV; // no room for the immediate
			w = word_t'($random(seed));
			w[OPC_HI:OPC_LO] = op;
			if ($random(seed) % 2 == 0) w[RS_HI:RS_LO] = prev_rd; // depend on last result
			prev_rd = w[RD_HI:RD_LO];
			prog[pos] = w;
			pos++;
			if (op == LDM) begin
				prog[pos] = word_t'($random(seed));
				pos++;
			end
		end
		prog[PROG_LEN - 1] = '0;
		prog[PROG_LEN - 1][OPC_HI:OPC_LO] = HLT;
	endtask

	// walks the program in order and queues OUT values
	task automatic run_model(input word_t in_val, output int n_out);
		int pc;
		int sh;
		logic done;
		logic alu;
		opcode_e op;
		word_t s;
		word_t d;
		word_t res;
		pc = 0;
		done = 1'b0;
		n_out = 0;
		while (!done && pc < PROG_LEN) begin
			op = opcode_e'(prog[pc][OPC_HI:OPC_LO]);
			s = model_regs[prog[pc][RS_HI:RS_LO]];
			d = model_regs[prog[pc][RD_HI:RD_LO]];
			sh = int'(prog[pc][SH_HI:SH_LO]);
			alu = op inside {ADD, SUB, AND, OR, NOT, INC, SHL, SHR};
			res = '0;
			case (op)
				MOV: model_regs[prog[pc][RD_HI:RD_LO]] = s;
				ADD: begin
					res = d + s;
					model_flags.carry = (res < d); // wrapped past the top
				end
				SUB: begin
					res = d - s;
					model_flags.carry = (d < s); // borrow
				end
				AND: res = d & s;
				OR: res = d | s;
				NOT: res = ~s;
				INC: begin
					res = s + 16'd1;
					model_flags.carry = (s == 16'hffff);
				end
				SHL: begin
					res = s << sh;
					model_flags.carry = 1'b0;
					if (sh > 0) model_flags.carry = s[WORD_W - sh];
				end
				SHR: begin
					res = s >> sh;
					model_flags.carry = 1'b0;
					if (sh > 0) model_flags.carry = s[sh - 1];
				end
				LDM: model_regs[prog[pc][RD_HI:RD_LO]] = prog[pc + 1];
				IN: model_regs[prog[pc][RD_HI:RD_LO]] = in_val;
				OUT: begin
					exp_out.push_back(s);
					n_out++;
				end
				HLT: done = 1'b1;
				default: ;
			endcase
			if (alu) begin
				model_regs[prog[pc][RD_HI:RD_LO]] = res;
				model_flags.zero = (res == '0);
				model_flags.negative = res[WORD_W-1];
			end
			pc += (op == LDM) ? 2 : 1;
		end
	endtask

	// each pulse takes the oldest expected value
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			run_outs++;
			assert (exp_out.size() > 0) else begin
				$display("ERROR: out_valid pulsed while the model expected no more output");
				other_errors++;
			end
			if (exp_out.size() > 0) begin
				check_word("out_value", exp_out.pop_front(), out_value);
			end
		end
	end

	initial begin
		word_t rdata;
		word_t run_in;
		logic err;
		int exp_count;
		int prop_fails;
		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		model_flags = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		for (int r = 0; r < NUM_RUNS; r++) begin
			run_in = word_t'($random(seed));
			in_value = run_in; // constant for the whole run
			build_program();
			run_model(run_in, exp_count);
			for (int i = 0; i < PROG_LEN; i++) begin
				apb_write(APB_ADDR_W'(i), prog[i], err);
				check_word($sformatf("run %0d load pslverr", r), '0, word_t'(err));
			end
			for (int i = 0; i < PROG_LEN; i++) begin
				apb_read(APB_ADDR_W'(i), rdata, err);
				check_word($sformatf("run %0d imem[%0d] readback", r, i), prog[i], rdata);
			end

			run_outs = 0;
			apb_write(CTRL_ADDR, 16'h0001, err);
			check_word($sformatf("run %0d start pslverr", r), '0, word_t'(err));
			// bus errors while the program runs
			apb_write(8'd5, ~prog[5], err);
			check_word($sformatf("run %0d locked write pslverr", r), 16'h0001, word_t'(err));
			apb_write(8'd200, 16'h5a5a, err);
			check_word($sformatf("run %0d unmapped write pslverr", r), 16'h0001, word_t'(err));
			apb_read(8'd100, rdata, err);
			check_word($sformatf("run %0d unmapped read pslverr", r), 16'h0001, word_t'(err));

			rdata = '0;
			while (!rdata[1]) begin
				apb_read(CTRL_ADDR, rdata, err);
			end
			check_word($sformatf("run %0d status", r), 16'h0002, rdata);
			repeat (3) @(posedge clk);
			#DRIVE_DELAY;
			check_word($sformatf("run %0d flags", r), word_t'(model_flags), word_t'(flags));
			check_word($sformatf("run %0d out count", r), word_t'(exp_count), word_t'(run_outs));
			apb_read(8'd5, rdata, err);
			check_word($sformatf("run %0d imem[5] after locked write", r), prog[5], rdata);
		end

		repeat (2) @(posedge clk);
		prop_fails = u_dut.u_props.failures;
		$display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
			checks, value_errors, other_errors, prop_fails);
		if (value_errors + other_errors + prop_fails == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- cpu_properties.sv
`timescale 1ns/1ps

module cpu_properties (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic out_valid
);

	int failures = 0;

	// no wait states on the host port
	pready_in_access: assert property (@(posedge clk) disable iff (reset)
		(psel && penable) |-> pready)
		else begin
			$error("pready low in an APB access cycle");
			failures++;
		end

	pslverr_in_access: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> (psel && penable))
		else begin
			$error("pslverr raised outside an APB access cycle");
			failures++;
		end

	// first cycle out of reset
	out_quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !out_valid)
		else begin
			$error("out_valid high in the cycle after reset");
			failures++;
		end

endmodule

bind cpu_top cpu_properties u_props (
	.clk(clk),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.out_valid(out_valid)
);

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter int IMEM_DEPTH = 64
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cpu_pkg::APB_ADDR_W-1:0] paddr,
	input cpu_pkg::word_t pwdata,
	output cpu_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	input cpu_pkg::word_t in_value,
	output cpu_pkg::word_t out_value,
	output logic out_valid,
	output cpu_pkg::flags_t flags
);
	import cpu_pkg::*;

	apb_if apb ();
	wb_if wb ();

	decode_t dec_d;
	decode_t dec_q;
	logic dec_d_valid;
	logic dec_q_valid;
	exec_t ex_d;
	exec_t ex_q;
	logic ex_d_valid;
	logic ex_q_valid;

	// host side of the apb bus
	assign apb.psel = psel;
	assign apb.penable = penable;
	assign apb.pwrite = pwrite;
	assign apb.paddr = paddr;
	assign apb.pwdata = pwdata;
	assign prdata = apb.prdata;
	assign pready = apb.pready;
	assign pslverr = apb.pslverr;

	fetch_decode #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) u_fetch (
		.clk(clk),
		.reset(reset),
		.apb(apb),
		.wb(wb),
		.dec(dec_d),
		.dec_valid(dec_d_valid)
	);

	stage_reg #(.payload_t(decode_t)) u_de_reg (
		.clk(clk),
		.reset(reset),
		.in_data(dec_d),
		.in_valid(dec_d_valid),
		.out_data(dec_q),
		.out_valid(dec_q_valid)
	);

	// ex_q comes back for write-back and forwarding
	stage_reg #(.payload_t(exec_t)) u_ew_reg (
		.clk(clk),
		.reset(reset),
		.in_data(ex_d),
		.in_valid(ex_d_valid),
		.out_data(ex_q),
		.out_valid(ex_q_valid)
	);

	execute_unit u_exec (
		.clk(clk),
		.reset(reset),
		.dec(dec_q),
		.dec_valid(dec_q_valid),
		.ex(ex_d),
		.ex_valid(ex_d_valid),
		.wbs(ex_q),
		.wbs_valid(ex_q_valid),
		.wb(wb),
		.in_value(in_value),
		.out_value(out_value),
		.out_valid(out_valid),
		.flags(flags)
	);

endmodule

//--- execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input logic clk,
	input logic reset,
	input cpu_pkg::decode_t dec,
	input logic dec_valid,
	output cpu_pkg::exec_t ex,
	output logic ex_valid,
	input cpu_pkg::exec_t wbs,
	input logic wbs_valid,
	wb_if.source wb,
	input cpu_pkg::word_t in_value,
	output cpu_pkg::word_t out_value,
	output logic out_valid,
	output cpu_pkg::flags_t flags
);
	import cpu_pkg::*;

	word_t op_s; // Rs operand
	word_t op_d; // Rd operand
	word_t result;
	logic [WORD_W:0] wide;
	logic carry;
	logic alu_op;
	logic we;
	logic is_out;

	// only the write-back stage forwards as older values come through the register file
	assign op_s = (wbs_valid && wbs.we && wbs.rd == dec.rs) ? wbs.result : dec.rs_val;
	assign op_d = (wbs_valid && wbs.we && wbs.rd == dec.rd) ? wbs.result : dec.rd_val;

	always_comb begin
		wide = '0;
		result = '0;
		carry = flags.carry; // kept unless the op defines it
		alu_op = 1'b0;
		we = 1'b0;
		is_out = 1'b0;
		case (dec.opcode)
			MOV: begin
				result = op_s;
				we = 1'b1;
			end
			ADD, SUB, INC: begin
				if (dec.opcode == ADD) begin
					wide = {1'b0, op_d} + {1'b0, op_s};
				end else if (dec.opcode == SUB) begin
					wide = {1'b0, op_d} - {1'b0, op_s}; // top bit is the borrow
				end else begin
					wide = {1'b0, op_s} + 1'b1;
				end
				result = wide[WORD_W-1:0];
				carry = wide[WORD_W];
				alu_op = 1'b1;
				we = 1'b1;
			end
			AND, OR, NOT: begin
				if (dec.opcode == AND) begin
					result = op_d & op_s;
				end else if (dec.opcode == OR) begin
					result = op_d | op_s;
				end else begin
					result = ~op_s;
				end
				alu_op = 1'b1;
				we = 1'b1;
			end
			SHL: begin
				wide = {1'b0, op_s} << dec.shamt; // bit 16 holds last bit out
				result = wide[WORD_W-1:0];
				carry = wide[WORD_W];
				alu_op = 1'b1;
				we = 1'b1;
			end
			SHR: begin
				wide = {op_s, 1'b0} >> dec.shamt; // bit 0 holds last bit out
				result = wide[WORD_W:1];
				carry = wide[0];
				alu_op = 1'b1;
				we = 1'b1;
			end
			LDM: begin
				result = dec.imm;
				we = 1'b1;
			end
			IN: begin
				result = in_value;
				we = 1'b1;
			end
			OUT: begin
				result = op_s;
				is_out = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign ex = '{we: we, rd: dec.rd, result: result, is_out: is_out};
	assign ex_valid = dec_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (dec_valid && alu_op) begin
			flags.zero <= (result == '0);
			flags.negative <= result[WORD_W-1];
			flags.carry <= carry;
		end
	end

	// write-back
	assign wb.we = wbs_valid & wbs.we;
	assign wb.waddr = wbs.rd;
	assign wb.wdata = wbs.result;

	// out port pulses in the OUT write-back cycle and keeps its value after
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_value <= '0;
		end else begin
			out_valid <= ex_valid & ex.is_out;
			if (ex_valid && ex.is_out) begin
				out_value <= ex.result;
			end
		end
	end

endmodule

//--- stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,
	input payload_t in_data,
	input logic in_valid,
	output payload_t out_data,
	output logic out_valid
);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_data <= '0;
			out_valid <= 1'b0;
		end else begin
			out_data <= in_data;
			out_valid <= in_valid; // a bubble passes as invalid
		end
	end

endmodule

//--- fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode #(
	parameter int IMEM_DEPTH = 64 // at most 255 since the top address is the control word
) (
	input logic clk,
	input logic reset,
	apb_if.completer apb,
	wb_if.sink wb,
	output cpu_pkg::decode_t dec,
	output logic dec_valid
);
	import cpu_pkg::*;

	localparam int IDX_W = (IMEM_DEPTH > 1) ? $clog2(IMEM_DEPTH) : 1;

	word_t imem [IMEM_DEPTH];

	logic [APB_ADDR_W-1:0] pc;
	logic [APB_ADDR_W-1:0] pc_plus1;
	logic [APB_ADDR_W-1:0] pc_step;
	logic running;
	logic halted;

	logic access;
	logic ctrl_sel;
	logic imem_sel;
	logic start;
	logic imem_we;

	word_t instr;
	word_t next_word;
	opcode_e opcode;
	reg_addr_t rs;
	reg_addr_t rd;
	word_t rs_val;
	word_t rd_val;

	// apb slave without wait states
	assign access = apb.psel & apb.penable;
	assign ctrl_sel = (apb.paddr == CTRL_ADDR);
	assign imem_sel = (apb.paddr < IMEM_DEPTH);
	assign start = access & apb.pwrite & ctrl_sel & apb.pwdata[0];
	assign imem_we = access & apb.pwrite & imem_sel & ~running; // program locked during a run

	assign apb.pready = access;
	assign apb.pslverr = access & ((~ctrl_sel & ~imem_sel) | (imem_sel & apb.pwrite & running));

	always_comb begin
		if (ctrl_sel) begin
			apb.prdata = word_t'({halted, running});
		end else if (imem_sel) begin
			apb.prdata = imem[apb.paddr[IDX_W-1:0]];
		end else begin
			apb.prdata = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[apb.paddr[IDX_W-1:0]] <= apb.pwdata;
		end
	end

	// current word and LDM immediate read as NOP past the end
	assign pc_plus1 = pc + 1'b1;
	assign instr = (pc < IMEM_DEPTH) ? imem[pc[IDX_W-1:0]] : '0;
	assign next_word = (pc_plus1 < IMEM_DEPTH) ? imem[pc_plus1[IDX_W-1:0]] : '0;

	assign opcode = opcode_e'(instr[OPC_HI:OPC_LO]);
	assign rs = instr[RS_HI:RS_LO];
	assign rd = instr[RD_HI:RD_LO];
	assign pc_step = (opcode == LDM) ? APB_ADDR_W'(2) : APB_ADDR_W'(1);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			running <= 1'b0;
			halted <= 1'b0;
		end else if (start) begin
			pc <= '0;
			running <= 1'b1;
			halted <= 1'b0;
		end else if (running) begin
			if (opcode == HLT) begin
				running <= 1'b0;
				halted <= 1'b1;
			end else begin
				pc <= pc + pc_step;
			end
		end
	end

	register_file u_regs (
		.clk(clk),
		.reset(reset),
		.wb(wb),
		.rs_addr(rs),
		.rd_addr(rd),
		.rs_data(rs_val),
		.rd_data(rd_val)
	);

	always_comb begin
		dec.opcode = opcode;
		dec.rs = rs;
		dec.rd = rd;
		dec.shamt = instr[SH_HI:SH_LO];
		dec.rs_val = rs_val;
		dec.rd_val = rd_val;
		dec.imm = next_word;
	end

	assign dec_valid = running & (opcode != HLT); // HLT never enters the pipe

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file (
	input logic clk,
	input logic reset,
	wb_if.sink wb,
	input cpu_pkg::reg_addr_t rs_addr,
	input cpu_pkg::reg_addr_t rd_addr,
	output cpu_pkg::word_t rs_data,
	output cpu_pkg::word_t rd_data
);
	import cpu_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we) begin
			regs[wb.waddr] <= wb.wdata;
		end
	end

	// write-first so a read of the register being written sees the new value
	always_comb begin
		if (wb.we && wb.waddr == rs_addr) begin
			rs_data = wb.wdata;
		end else begin
			rs_data = regs[rs_addr];
		end
		if (wb.we && wb.waddr == rd_addr) begin
			rd_data = wb.wdata;
		end else begin
			rd_data = regs[rd_addr];
		end
	end

endmodule

//--- cpu_intf.sv
`timescale 1ns/1ps

interface apb_if;
	import cpu_pkg::*;

	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	word_t pwdata;
	word_t prdata;
	logic pready;
	logic pslverr;

	modport requester (
		output psel, penable, pwrite, paddr, pwdata,
		input prdata, pready, pslverr
	);

	modport completer (
		input psel, penable, pwrite, paddr, pwdata,
		output prdata, pready, pslverr
	);

endinterface

// register write-back path
interface wb_if;
	import cpu_pkg::*;

	logic we;
	reg_addr_t waddr;
	word_t wdata;

	modport source (
		output we, waddr, wdata
	);

	modport sink (
		input we, waddr, wdata
	);

endinterface

//--- cpu_pkg.sv
package cpu_pkg;

	localparam int WORD_W = 16;
	localparam int REG_ADDR_W = 3;
	localparam int NUM_REGS = 8;
	localparam int OPC_W = 5;
	localparam int SHAMT_W = 4;

	// apb host port
	localparam int APB_ADDR_W = 8;
	localparam logic [APB_ADDR_W-1:0] CTRL_ADDR = '1; // control and status word

	// instruction field positions
	localparam int OPC_HI = 15;
	localparam int OPC_LO = 11;
	localparam int RS_HI = 10;
	localparam int RS_LO = 8;
	localparam int RD_HI = 7;
	localparam int RD_LO = 5;
	localparam int SH_HI = 4;
	localparam int SH_LO = 1;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// codes not listed here behave as NOP
	typedef enum logic [OPC_W-1:0] {
		NOP = 5'd0,
		MOV = 5'd1,
		ADD = 5'd2,
		SUB = 5'd3,
		AND = 5'd4,
		OR  = 5'd5,
		NOT = 5'd6,
		INC = 5'd7,
		SHL = 5'd8,
		SHR = 5'd9,
		LDM = 5'd10, // immediate in the following word
		IN  = 5'd11,
		OUT = 5'd12,
		HLT = 5'd13
	} opcode_e;

	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
	} flags_t;

	// decode to execute
	typedef struct packed {
		opcode_e opcode;
		reg_addr_t rs;
		reg_addr_t rd;
		logic [SHAMT_W-1:0] shamt;
		word_t rs_val;
		word_t rd_val;
		word_t imm;
	} decode_t;

	// execute to write-back
	typedef struct packed {
		logic we;
		reg_addr_t rd;
		word_t result;
		logic is_out;
	} exec_t;

endpackage
